// File: common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath word width
`define WORD_W 32
// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Data memory size in words
`define DMEM_DEPTH 256
`define DMEM_ADDR_W 8 // log2 of DMEM_DEPTH

`endif

// File: common/cpu_types_pkg.sv
`include "cpu_macros.svh"

package cpu_types_pkg;

	// Basic datapath types
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] regbits_t;

	// Destination register select, decoded at writeback
	typedef enum logic [1:0] {
		SEL_RD = 2'd0, // R-type destination
		SEL_RT = 2'd1, // I-type destination
		SEL_RA = 2'd2  // Link register r31 for jal
	} reg_dest_t;

	// Memory stage operation
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1, // Word load, writeback takes memory data
		MEM_STORE = 2'd2  // Word store at result address
	} mem_op_t;

endpackage

// File: mem_stage/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     enable_ex_mem,
	input  logic                     flush_ex_mem,
	input  logic                     wen_ex,
	input  cpu_types_pkg::word_t     result_ex,
	input  cpu_types_pkg::word_t     store_data_ex,
	input  cpu_types_pkg::mem_op_t   mem_op_ex,
	input  cpu_types_pkg::reg_dest_t reg_dest_ex,
	input  cpu_types_pkg::regbits_t  rt_ex,
	input  cpu_types_pkg::regbits_t  rd_ex,
	input  logic                     halt_ex,
	output logic                     wen_mem,
	output cpu_types_pkg::word_t     result_mem,
	output cpu_types_pkg::word_t     store_data_mem,
	output cpu_types_pkg::mem_op_t   mem_op_mem,
	output cpu_types_pkg::reg_dest_t reg_dest_mem,
	output cpu_types_pkg::regbits_t rt_mem,
	output cpu_types_pkg::regbits_t rd_mem,
	output logic                     halt_mem
);
	import cpu_types_pkg::*;

	// Next state of every latched field
	logic      wen_nxt, halt_nxt;
	word_t     result_nxt, store_data_nxt;
	mem_op_t   mem_op_nxt;
	reg_dest_t reg_dest_nxt;
	regbits_t  rt_nxt, rd_nxt;

	always_comb begin : nxt_logic
		// Default is hold, covers a stall
		wen_nxt        = wen_mem;
		result_nxt     = result_mem;
		store_data_nxt = store_data_mem;
		mem_op_nxt     = mem_op_mem;
		reg_dest_nxt   = reg_dest_mem;
		rt_nxt         = rt_mem;
		rd_nxt         = rd_mem;
		halt_nxt       = halt_mem;

		if (flush_ex_mem) begin // Squash wins over enable
			wen_nxt        = 1'b0;
			result_nxt     = '0;
			store_data_nxt = '0;
			mem_op_nxt     = MEM_NONE; // No store leaks past a flush
			reg_dest_nxt   = SEL_RD;
			rt_nxt         = '0;
			rd_nxt         = '0;
			halt_nxt       = 1'b0;
		end else if (enable_ex_mem) begin // Take new EX results
			wen_nxt        = wen_ex;
			result_nxt     = result_ex;
			store_data_nxt = store_data_ex;
			mem_op_nxt     = mem_op_ex;
			reg_dest_nxt   = reg_dest_ex;
			rt_nxt         = rt_ex;
			rd_nxt         = rd_ex;
			halt_nxt       = halt_ex;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin : reg_logic
		if (!nRST) begin // Come out of reset holding a bubble
			wen_mem        <= 1'b0;
			result_mem     <= '0;
			store_data_mem <= '0;
			mem_op_mem     <= MEM_NONE;
			reg_dest_mem   <= SEL_RD;
			rt_mem         <= '0;
			rd_mem         <= '0;
			halt_mem       <= 1'b0;
		end else begin
			wen_mem        <= wen_nxt;
			result_mem     <= result_nxt;
			store_data_mem <= store_data_nxt;
			mem_op_mem     <= mem_op_nxt;
			reg_dest_mem   <= reg_dest_nxt;
			rt_mem         <= rt_nxt;
			rd_mem         <= rd_nxt;
			halt_mem       <= halt_nxt;
		end
	end

endmodule

// File: mem_stage/data_mem.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module data_mem (
	input  logic                   CLK,
	input  cpu_types_pkg::word_t   result_mem,     // Byte address from ALU
	input  cpu_types_pkg::word_t   store_data_mem,
	input  cpu_types_pkg::mem_op_t mem_op_mem,
	output cpu_types_pkg::word_t   dmemload
);
	import cpu_types_pkg::*;

	// Word storage, no reset
	word_t mem [`DMEM_DEPTH];

	logic [`DMEM_ADDR_W-1:0] waddr;
	logic                    store_en;

	// Word aligned access only
	// Bits 1:0 are the byte offset and are ignored
	assign waddr = result_mem[`DMEM_ADDR_W+1:2];

	assign store_en = (mem_op_mem == MEM_STORE);

	// Load path is combinational within the MEM cycle
	// MEM/WB picks it up at the next edge
	assign dmemload = mem[waddr];

	// Store commits at the edge that ends the MEM cycle
	// A stall keeps the same store in EX/MEM, rewriting the same word
	always_ff @(posedge CLK) begin : store_logic
		if (store_en) begin
			mem[waddr] <= store_data_mem;
		end
	end

endmodule

// File: wb_stage/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     enable_mem_wb,
	input  logic                     flush_mem_wb,
	input  logic                     wen_mem,
	input  cpu_types_pkg::word_t     result_mem,
	input  cpu_types_pkg::mem_op_t   mem_op_mem,
	input  cpu_types_pkg::reg_dest_t reg_dest_mem,
	input  cpu_types_pkg::regbits_t  rt_mem,
	input  cpu_types_pkg::regbits_t  rd_mem,
	input  logic                     halt_mem,
	input  cpu_types_pkg::word_t     dmemload,     // Load data from data memory
	output logic                     wen_wb,
	output cpu_types_pkg::word_t     result_wb,
	output cpu_types_pkg::word_t     dmemload_wb,
	output cpu_types_pkg::mem_op_t   mem_op_wb,
	output cpu_types_pkg::reg_dest_t reg_dest_wb,
	output cpu_types_pkg::regbits_t  rt_wb,
	output cpu_types_pkg::regbits_t  rd_wb,
	output logic                     halt
);
	import cpu_types_pkg::*;

	logic      wen_nxt, halt_nxt;
	word_t     result_nxt, dmemload_nxt;
	mem_op_t   mem_op_nxt; // Kept only for the writeback source select
	reg_dest_t reg_dest_nxt;
	regbits_t  rt_nxt, rd_nxt;

	always_comb begin : nxt_logic
		wen_nxt      = wen_wb; // Hold unless told otherwise
		result_nxt   = result_wb;
		dmemload_nxt = dmemload_wb;
		mem_op_nxt   = mem_op_wb;
		reg_dest_nxt = reg_dest_wb;
		rt_nxt       = rt_wb;
		rd_nxt       = rd_wb;
		halt_nxt     = halt;

		if (flush_mem_wb) begin
			// Bubble, nothing written and no halt
			wen_nxt      = 1'b0;
			result_nxt   = '0;
			dmemload_nxt = '0;
			mem_op_nxt   = MEM_NONE;
			reg_dest_nxt = SEL_RD;
			rt_nxt       = '0;
			rd_nxt       = '0;
			halt_nxt     = 1'b0;
		end else if (enable_mem_wb) begin
			wen_nxt      = wen_mem;
			result_nxt   = result_mem;
			dmemload_nxt = dmemload; // Sampled at end of MEM cycle
			mem_op_nxt   = mem_op_mem;
			reg_dest_nxt = reg_dest_mem;
			rt_nxt       = rt_mem;
			rd_nxt       = rd_mem;
			halt_nxt     = halt_mem;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin : reg_logic
		if (!nRST) begin
			wen_wb      <= 1'b0;
			result_wb   <= '0;
			dmemload_wb <= '0;
			mem_op_wb   <= MEM_NONE;
			reg_dest_wb <= SEL_RD;
			rt_wb       <= '0;
			rd_wb       <= '0;
			halt        <= 1'b0;
		end else begin
			wen_wb      <= wen_nxt;
			result_wb   <= result_nxt;
			dmemload_wb <= dmemload_nxt;
			mem_op_wb   <= mem_op_nxt;
			reg_dest_wb <= reg_dest_nxt;
			rt_wb       <= rt_nxt;
			rd_wb       <= rd_nxt;
			halt        <= halt_nxt;
		end
	end

endmodule

// File: wb_stage/reg_file.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module reg_file (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     wen_wb,
	input  cpu_types_pkg::word_t     result_wb,
	input  cpu_types_pkg::word_t     dmemload_wb,
	input  cpu_types_pkg::mem_op_t   mem_op_wb,
	input  cpu_types_pkg::reg_dest_t reg_dest_wb,
	input  cpu_types_pkg::regbits_t  rt_wb,
	input  cpu_types_pkg::regbits_t  rd_wb,
	input  cpu_types_pkg::regbits_t  rsel1,
	input  cpu_types_pkg::regbits_t  rsel2,
	output cpu_types_pkg::word_t     rdat1,
	output cpu_types_pkg::word_t     rdat2,
	output logic                     wb_wen,  // Already masked for r0
	output cpu_types_pkg::regbits_t  wb_addr,
	output cpu_types_pkg::word_t     wb_data
);
	import cpu_types_pkg::*;

	localparam int NREGS = 2 ** `REG_ADDR_W;

	word_t regs [NREGS];

	// Writeback source, memory data only for loads
	assign wb_data = (mem_op_wb == MEM_LOAD) ? dmemload_wb : result_wb;

	// Destination decode
	always_comb begin : dest_decode
		case (reg_dest_wb)
			SEL_RT:  wb_addr = rt_wb;
			SEL_RA:  wb_addr = regbits_t'(NREGS - 1); // r31 link register
			default: wb_addr = rd_wb; // SEL_RD
		endcase
	end

	// r0 is hardwired to zero so a write to it is dropped here
	assign wb_wen = wen_wb && (wb_addr != '0);

	always_ff @(posedge CLK, negedge nRST) begin : reg_write
		if (!nRST) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_wen) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Read ports, no bypass from the write in the same cycle
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

endmodule

// File: hdl/mem_wb_pipe.sv
`timescale 1ns/1ps

module mem_wb_pipe (
	input  logic                     CLK,
	input  logic                     nRST,
	// Hazard unit strobes
	input  logic                     enable_ex_mem,
	input  logic                     flush_ex_mem,
	input  logic                     enable_mem_wb,
	input  logic                     flush_mem_wb,
	// Execute stage results
	input  logic                     wen_ex,
	input  cpu_types_pkg::word_t     result_ex,
	input  cpu_types_pkg::word_t     store_data_ex,
	input  cpu_types_pkg::mem_op_t   mem_op_ex,
	input  cpu_types_pkg::reg_dest_t reg_dest_ex,
	input  cpu_types_pkg::regbits_t  rt_ex,
	input  cpu_types_pkg::regbits_t  rd_ex,
	input  logic                     halt_ex,
	// Register file read ports
	input  cpu_types_pkg::regbits_t  rsel1,
	input  cpu_types_pkg::regbits_t  rsel2,
	output cpu_types_pkg::word_t     rdat1,
	output cpu_types_pkg::word_t     rdat2,
	// Writeback seen this cycle
	output logic                     wb_wen,
	output cpu_types_pkg::regbits_t  wb_addr,
	output cpu_types_pkg::word_t     wb_data,
	output logic                     halt
);
	import cpu_types_pkg::*;

	// EX/MEM outputs
	logic      wen_mem, halt_mem;
	word_t     result_mem, store_data_mem;
	mem_op_t   mem_op_mem;
	reg_dest_t reg_dest_mem;
	regbits_t  rt_mem, rd_mem;

	word_t     dmemload; // Combinational load data

	// MEM/WB outputs
	logic      wen_wb;
	word_t     result_wb, dmemload_wb;
	mem_op_t   mem_op_wb;
	reg_dest_t reg_dest_wb;
	regbits_t  rt_wb, rd_wb;

	ex_mem_reg i_ex_mem_reg (
		.CLK, .nRST, .enable_ex_mem, .flush_ex_mem,
		.wen_ex, .result_ex, .store_data_ex, .mem_op_ex, .reg_dest_ex, .rt_ex, .rd_ex,
		.halt_ex, .wen_mem, .result_mem, .store_data_mem, .mem_op_mem, .reg_dest_mem,
		.rt_mem, .rd_mem, .halt_mem
	);

	data_mem i_data_mem (
		.CLK, .result_mem, .store_data_mem, .mem_op_mem, .dmemload
	);

	mem_wb_reg i_mem_wb_reg (
		.CLK, .nRST, .enable_mem_wb, .flush_mem_wb,
		.wen_mem, .result_mem, .mem_op_mem, .reg_dest_mem, .rt_mem, .rd_mem, .halt_mem,
		.dmemload, .wen_wb, .result_wb, .dmemload_wb, .mem_op_wb, .reg_dest_wb,
		.rt_wb, .rd_wb, .halt
	);

	reg_file i_reg_file (
		.CLK, .nRST, .wen_wb, .result_wb, .dmemload_wb, .mem_op_wb, .reg_dest_wb,
		.rt_wb, .rd_wb, .rsel1, .rsel2, .rdat1, .rdat2, .wb_wen, .wb_addr, .wb_data
	);

endmodule

// File: tb/mem_wb_asserts.sv
`timescale 1ns/1ps

module mem_wb_asserts (
	input logic                    CLK,
	input logic                    nRST,
	input logic                    enable_mem_wb,
	input logic                    flush_mem_wb,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	input cpu_types_pkg::word_t    rdat1,
	input cpu_types_pkg::word_t    rdat2,
	input logic                    wb_wen,
	input cpu_types_pkg::regbits_t wb_addr,
	input cpu_types_pkg::word_t    wb_data,
	input logic                    halt
);
	int fail_count = 0; // Assertion failures so far

	// Flushed MEM/WB presents a bubble one edge later
	flush_gives_bubble: assert property (@(posedge CLK) disable iff (!nRST)
		flush_mem_wb |=> (!wb_wen && !halt))
		else begin
			fail_count++;
			$error("MEM/WB flush left a register write or halt at writeback");
		end

	// Stalled MEM/WB keeps presenting the same writeback
	stall_holds_wb: assert property (@(posedge CLK) disable iff (!nRST)
		(!enable_mem_wb && !flush_mem_wb) |=>
			($stable(wb_wen) && $stable(wb_addr) && $stable(wb_data) && $stable(halt)))
		else begin
			fail_count++;
			$error("Writeback outputs changed while MEM/WB was stalled");
		end

	// r0 reads back zero on both ports
	r0_reads_zero: assert property (@(posedge CLK) disable iff (!nRST)
		((rsel1 != '0) || (rdat1 == '0)) && ((rsel2 != '0) || (rdat2 == '0)))
		else begin
			fail_count++;
			$error("Register zero read back a nonzero value");
		end

endmodule

bind mem_wb_pipe mem_wb_asserts i_mem_wb_asserts (.*);

// File: tb/mem_wb_checker.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module mem_wb_checker (
	input  logic                     CLK,
	input  logic                     nRST,
	input  int                       phase,
	input  logic                     enable_ex_mem,
	input  logic                     flush_ex_mem,
	input  logic                     enable_mem_wb,
	input  logic                     flush_mem_wb,
	input  logic                     wen_ex,
	input  cpu_types_pkg::word_t     result_ex,
	input  cpu_types_pkg::word_t     store_data_ex,
	input  cpu_types_pkg::mem_op_t   mem_op_ex,
	input  cpu_types_pkg::reg_dest_t reg_dest_ex,
	input  cpu_types_pkg::regbits_t  rt_ex,
	input  cpu_types_pkg::regbits_t  rd_ex,
	input  logic                     halt_ex,
	input  cpu_types_pkg::regbits_t  rsel1,
	input  cpu_types_pkg::regbits_t  rsel2,
	input  cpu_types_pkg::word_t     rdat1,
	input  cpu_types_pkg::word_t     rdat2,
	input  logic                     wb_wen,
	input  cpu_types_pkg::regbits_t  wb_addr,
	input  cpu_types_pkg::word_t     wb_data,
	input  logic                     halt,
	output int                       err_count,
	output int                       check_count
);
	import cpu_types_pkg::*;

	// Model EX/MEM stage
	logic      em_wen, em_halt;
	word_t     em_result, em_sdata;
	mem_op_t   em_op;
	reg_dest_t em_dest;
	regbits_t  em_rt, em_rd;

	// Model MEM/WB stage
	logic      mw_wen, mw_halt;
	word_t     mw_result, mw_load; // Load data as read from model memory
	mem_op_t   mw_op;
	reg_dest_t mw_dest;
	regbits_t  mw_rt, mw_rd;

	word_t model_regs [32];
	word_t model_mem [`DMEM_DEPTH]; // Unwritten words stay X like the DUT

	initial begin
		err_count   = 0;
		check_count = 0;
	end

	// Expected writeback as {wen, addr, data}
	function automatic logic [37:0] wb_ref(input logic wen, input word_t result,
			input word_t load, input mem_op_t op, input reg_dest_t dest,
			input regbits_t rt, input regbits_t rd);
		regbits_t addr;
		word_t    data;
		case (dest)
			SEL_RT:  addr = rt;
			SEL_RA:  addr = 5'd31; // Link register
			default: addr = rd;
		endcase
		data = (op == MEM_LOAD) ? load : result; // Loads take memory data
		return {wen && (addr != 5'd0), addr, data};
	endfunction

	function automatic string phase_name(input int p);
		case (p)
			0:       return "reset";
			1:       return "fill";
			2:       return "alu_dest";
			3:       return "load_store";
			4:       return "flush";
			5:       return "stall_r0";
			default: return "random";
		endcase
	endfunction

	task automatic empty_ex_mem();
		em_wen    = 1'b0;
		em_halt   = 1'b0;
		em_result = '0;
		em_sdata  = '0;
		em_op     = MEM_NONE;
		em_dest   = SEL_RD;
		em_rt     = '0;
		em_rd     = '0;
	endtask

	task automatic bubble_mem_wb();
		mw_wen    = 1'b0;
		mw_halt   = 1'b0;
		mw_result = '0;
		mw_load   = '0;
		mw_op     = MEM_NONE;
		mw_dest   = SEL_RD;
		mw_rt     = '0;
		mw_rd     = '0;
	endtask

	always @(posedge CLK or negedge nRST) begin : model_update
		logic [37:0] wb;
		if (!nRST) begin
			empty_ex_mem();
			bubble_mem_wb();
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
		end else begin
			// Register write from MEM/WB contents before this edge
			wb = wb_ref(mw_wen, mw_result, mw_load, mw_op, mw_dest, mw_rt, mw_rd);
			if (wb[37]) begin
				model_regs[wb[36:32]] = wb[31:0];
			end
			if (flush_mem_wb) begin
				bubble_mem_wb();
			end else if (enable_mem_wb) begin
				mw_wen    = em_wen;
				mw_halt   = em_halt;
				mw_result = em_result;
				mw_load   = model_mem[em_result[`DMEM_ADDR_W+1:2]]; // Before this edge's store
				mw_op     = em_op;
				mw_dest   = em_dest;
				mw_rt     = em_rt;
				mw_rd     = em_rd;
			end
			if (em_op == MEM_STORE) begin // Store commits as it leaves EX/MEM
				model_mem[em_result[`DMEM_ADDR_W+1:2]] = em_sdata;
			end
			if (flush_ex_mem) begin
				empty_ex_mem();
			end else if (enable_ex_mem) begin
				em_wen    = wen_ex;
				em_halt   = halt_ex;
				em_result = result_ex;
				em_sdata  = store_data_ex;
				em_op     = mem_op_ex;
				em_dest   = reg_dest_ex;
				em_rt     = rt_ex;
				em_rd     = rd_ex;
			end
		end
	end

	task automatic compare_word(input string what, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("FAIL %s: %s expected %h, actual %h", phase_name(phase), what,
				expected, actual);
		end
	endtask

	always @(posedge CLK) begin : compare
		logic [37:0] exp_wb;
		#2; // Past the edge, outputs settled
		if (nRST) begin
			exp_wb = wb_ref(mw_wen, mw_result, mw_load, mw_op, mw_dest, mw_rt, mw_rd);
			compare_word("wb_wen", word_t'(exp_wb[37]), word_t'(wb_wen));
			compare_word("wb_addr", word_t'(exp_wb[36:32]), word_t'(wb_addr));
			compare_word("wb_data", exp_wb[31:0], wb_data);
			compare_word("halt", word_t'(mw_halt), word_t'(halt));
			compare_word("rdat1", model_regs[rsel1], rdat1); // No bypass expected
			compare_word("rdat2", model_regs[rsel2], rdat2);
		end
	end

endmodule

// File: tb/tb_mem_wb_pipe.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module tb_mem_wb_pipe;
	import cpu_types_pkg::*;

	localparam int RESET_CYCLES    = 4;
	localparam int DIRECTED_CYCLES = 32 + `DMEM_DEPTH + 3 + 50; // Sweep, fill, short phases
	localparam int RANDOM_CYCLES   = 300;
	localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

	logic      CLK = 1'b0;
	logic      nRST;
	logic      enable_ex_mem, flush_ex_mem, enable_mem_wb, flush_mem_wb;
	logic      wen_ex, halt_ex;
	word_t     result_ex, store_data_ex;
	mem_op_t   mem_op_ex;
	reg_dest_t reg_dest_ex;
	regbits_t  rt_ex, rd_ex, rsel1, rsel2;
	word_t     rdat1, rdat2, wb_data;
	logic      wb_wen, halt;
	regbits_t  wb_addr;
	int        phase;
	int        err_count, check_count;

	mem_wb_pipe i_dut (.*);
	mem_wb_checker i_checker (.*);

	always #5 CLK = ~CLK; // 10 ns period

	// Execute stage outputs, no wait
	task automatic present(input mem_op_t op, input reg_dest_t dest, input regbits_t rt,
			input regbits_t rd, input word_t result, input word_t sdata, input logic wen,
			input logic hlt);
		mem_op_ex     = op;
		reg_dest_ex   = dest;
		rt_ex         = rt;
		rd_ex         = rd;
		result_ex     = result;
		store_data_ex = sdata;
		wen_ex        = wen;
		halt_ex       = hlt;
	endtask

	// One instruction for one cycle, falling edge to falling edge
	task automatic issue(input mem_op_t op, input reg_dest_t dest, input regbits_t rt,
			input regbits_t rd, input word_t result, input word_t sdata, input logic wen,
			input logic hlt);
		present(op, dest, rt, rd, result, sdata, wen, hlt);
		@(negedge CLK);
	endtask

	task automatic idle(input int n);
		repeat (n) issue(MEM_NONE, SEL_RD, '0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	function automatic word_t fill_word(input int a);
		return {8'hc3, a[7:0], ~a[7:0], a[7:0] ^ 8'h5a}; // Every address bit shows
	endfunction

	initial begin : stimulus
		int      sel;
		mem_op_t op;
		void'($urandom(32'heee));
		nRST          = 1'b0;
		phase         = 0;
		enable_ex_mem = 1'b1;
		enable_mem_wb = 1'b1;
		flush_ex_mem  = 1'b0;
		flush_mem_wb  = 1'b0;
		rsel1         = '0;
		rsel2         = '0;
		present(MEM_NONE, SEL_RD, '0, '0, '0, '0, 1'b0, 1'b0);
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;
		for (int i = 0; i < 32; i++) begin // All registers read zero
			rsel1 = regbits_t'(i);
			rsel2 = regbits_t'(31 - i);
			idle(1);
		end
		phase = 1;
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			issue(MEM_STORE, SEL_RD, '0, '0, word_t'(i << 2), fill_word(i), 1'b0, 1'b0);
		end
		idle(3);
		phase = 2;
		rsel1 = 5'd4;
		rsel2 = 5'd31;
		issue(MEM_NONE, SEL_RD, 5'd9, 5'd4, 32'h1234_5678, '0, 1'b1, 1'b0);
		issue(MEM_NONE, SEL_RT, 5'd6, 5'd4, 32'hcafe_0001, '0, 1'b1, 1'b0); // rd ignored
		issue(MEM_NONE, SEL_RA, 5'd6, 5'd7, 32'h0000_0400, '0, 1'b1, 1'b0); // jal link
		rsel1 = 5'd6;
		idle(4);
		phase = 3;
		rsel1 = 5'd10;
		rsel2 = 5'd11;
		issue(MEM_STORE, SEL_RD, '0, '0, 32'h0000_0050, 32'hdead_beef, 1'b0, 1'b0);
		issue(MEM_LOAD, SEL_RT, 5'd10, '0, 32'h0000_0050, '0, 1'b1, 1'b0); // Just stored
		issue(MEM_LOAD, SEL_RT, 5'd11, '0, 32'h0000_0190, '0, 1'b1, 1'b0);
		idle(4);
		phase = 4;
		rsel1 = 5'd12;
		rsel2 = 5'd14;
		flush_ex_mem = 1'b1; // Squash at entry, incl. a store
		issue(MEM_NONE, SEL_RD, '0, 5'd12, 32'h1111_1111, '0, 1'b1, 1'b1);
		issue(MEM_STORE, SEL_RD, '0, '0, 32'h0000_0050, 32'h0bad_0bad, 1'b0, 1'b0);
		flush_ex_mem = 1'b0;
		issue(MEM_NONE, SEL_RD, '0, 5'd13, 32'h2222_2222, '0, 1'b1, 1'b1);
		flush_mem_wb = 1'b1; // Kills r13 and its halt on the way in
		issue(MEM_LOAD, SEL_RD, '0, 5'd14, 32'h0000_0050, '0, 1'b1, 1'b0);
		flush_mem_wb = 1'b0;
		idle(4);
		phase = 5;
		rsel1 = 5'd15;
		rsel2 = 5'd16;
		issue(MEM_NONE, SEL_RD, '0, 5'd15, 32'h3333_3333, '0, 1'b1, 1'b0);
		enable_ex_mem = 1'b0; // Whole back end frozen
		enable_mem_wb = 1'b0;
		idle(3);
		enable_ex_mem = 1'b1;
		enable_mem_wb = 1'b1;
		issue(MEM_LOAD, SEL_RT, 5'd16, '0, 32'h0000_0300, '0, 1'b1, 1'b0);
		idle(1);
		enable_ex_mem = 1'b0; // Load held inside MEM/WB
		enable_mem_wb = 1'b0;
		idle(3);
		enable_ex_mem = 1'b1;
		enable_mem_wb = 1'b1;
		rsel1 = 5'd0;
		issue(MEM_NONE, SEL_RD, '0, 5'd0, 32'hffff_ffff, '0, 1'b1, 1'b0); // r0 dropped
		issue(MEM_LOAD, SEL_RT, 5'd0, '0, 32'h0000_0010, '0, 1'b1, 1'b0);
		idle(4);
		phase = 6;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			enable_ex_mem = ($urandom % 8) != 0;
			enable_mem_wb = ($urandom % 8) != 0;
			flush_ex_mem  = ($urandom % 16) == 0;
			flush_mem_wb  = ($urandom % 16) == 0;
			rsel1         = regbits_t'($urandom);
			rsel2         = regbits_t'($urandom);
			sel           = $urandom % 10;
			op = (sel < 3) ? MEM_LOAD : ((sel < 5) ? MEM_STORE : MEM_NONE);
			issue(op, reg_dest_t'($urandom % 3), regbits_t'($urandom), regbits_t'($urandom),
				$urandom, $urandom, op != MEM_STORE, ($urandom % 32) == 0);
		end
		enable_ex_mem = 1'b1;
		enable_mem_wb = 1'b1;
		flush_ex_mem  = 1'b0;
		flush_mem_wb  = 1'b0;
		idle(5); // Drain
		$display("Checks %0d, value errors %0d, assertion failures %0d", check_count,
			err_count, i_dut.i_mem_wb_asserts.fail_count);
		if (err_count == 0 && i_dut.i_mem_wb_asserts.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#((TOTAL_CYCLES + 50) * 10);
		$display("Timeout: stimulus did not finish within %0d cycles", TOTAL_CYCLES + 50);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+common
common/cpu_types_pkg.sv
mem_stage/ex_mem_reg.sv
mem_stage/data_mem.sv
wb_stage/mem_wb_reg.sv
wb_stage/reg_file.sv
hdl/mem_wb_pipe.sv
tb/mem_wb_asserts.sv
tb/mem_wb_checker.sv
tb/tb_mem_wb_pipe.sv
